// File: src/dma_cfg.svh
`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

// width of one data word on both the stream and the memory-mapped side
`define DMA_DATA_WIDTH 32

// byte address width of the write master
`define DMA_ADDR_WIDTH 32

// width of the descriptor byte length and of the length counter
`define DMA_LEN_WIDTH 32

// log2 of the number of words the write FIFO can buffer
`define DMA_FIFO_DEPTH_LOG2 4

// number of byte lanes in one data word
`define DMA_BYTES_PER_WORD 4

`endif

// File: src/stream_pkg.sv
`default_nettype none

`include "dma_cfg.svh"

package stream_pkg;

  // one data word as it sits in the FIFO and on the master bus
  typedef logic [`DMA_DATA_WIDTH-1:0] stream_word_t;

  // a streaming beat arrives in network order with the first byte in the top lane
  typedef struct packed {
    logic         valid; // beat is offered this cycle
    stream_word_t data;  // payload in network byte order
  } st_beat_t;

endpackage

`default_nettype wire

// File: src/command_pkg.sv
`default_nettype none

`include "dma_cfg.svh"

package command_pkg;

  // one enable bit per byte lane of the write data
  typedef logic [`DMA_BYTES_PER_WORD-1:0] byteenable_t;

  // a transfer request as software hands it over
  typedef struct packed {
    logic [`DMA_ADDR_WIDTH-1:0] address; // start byte address whose low bits get dropped
    logic [`DMA_LEN_WIDTH-1:0]  length;  // number of bytes to write
  } descriptor_t;

  // everything the write master presents to the memory-mapped fabric
  typedef struct packed {
    logic                       write;      // a write is requested this cycle
    logic [`DMA_ADDR_WIDTH-1:0] address;    // word aligned byte address
    byteenable_t                byteenable; // lanes that carry valid bytes
    logic [`DMA_DATA_WIDTH-1:0] writedata;  // little endian data word
  } master_cmd_t;

endpackage

`default_nettype wire

// File: src/write_fifo.sv
`default_nettype none
`timescale 1ns/10ps

`include "dma_cfg.svh"

module write_fifo
  import stream_pkg::*;
#(
  parameter int DEPTH_LOG2 = `DMA_FIFO_DEPTH_LOG2 // any depth that is a power of two works
)
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         fifo_write, // push request from the stream side
  input  stream_word_t fifo_data,  // byte swapped word to store
  input  logic         fifo_read,  // pop request from the write master
  output stream_word_t fifo_q,     // oldest stored word shown ahead of the pop
  output logic         fifo_full,
  output logic         fifo_empty
);

  localparam int DEPTH = 2 ** DEPTH_LOG2; // number of storage slots

  stream_word_t          mem [DEPTH]; // circular storage
  logic [DEPTH_LOG2-1:0] wr_ptr;      // next slot to fill and it wraps on its own
  logic [DEPTH_LOG2-1:0] rd_ptr;      // slot of the oldest word
  logic [DEPTH_LOG2:0]   count;       // occupancy with one extra bit so full is distinct from empty
  logic                  push;        // a write that really lands
  logic                  pop;         // a read that really retires a word

  assign push = fifo_write & ~fifo_full; // writes into a full buffer are dropped
  assign pop  = fifo_read & ~fifo_empty; // reads from an empty buffer are ignored

  assign fifo_full  = (count == (DEPTH_LOG2 + 1)'(DEPTH)); // every slot holds a word
  assign fifo_empty = (count == '0);                       // nothing left to show

  // show-ahead read so the master sees the head word without asking for it
  assign fifo_q = mem[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      mem[wr_ptr] <= fifo_data; // the slot at the write pointer takes the new word
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0; // buffer starts empty
    end
    else
    begin
      if (push)
      begin
        wr_ptr <= wr_ptr + 1'b1; // advance past the slot just written
      end
      if (pop)
      begin
        rd_ptr <= rd_ptr + 1'b1; // next word becomes visible after the edge
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1; // only a push so one more word
        2'b01:   count <= count - 1'b1; // only a pop so one fewer word
        default: count <= count;        // both or neither leave the level unchanged
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/write_master.sv
`default_nettype none
`timescale 1ns/10ps

`include "dma_cfg.svh"

module write_master
  import stream_pkg::*;
  import command_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         command_valid,      // descriptor offered by the host
  input  descriptor_t  command_data,       // start address and byte length
  output logic         command_ready,      // high only while the master is idle
  input  stream_word_t fifo_q,             // head of the write FIFO
  input  logic         fifo_empty,
  output logic         fifo_read,          // retire the head word
  output master_cmd_t  master,             // write request towards the fabric
  input  logic         master_waitrequest, // fabric holds the current request
  output logic         response_valid      // one cycle pulse when a descriptor completes
);

  localparam int ADDR_W = `DMA_ADDR_WIDTH;
  localparam int LEN_W  = `DMA_LEN_WIDTH;
  localparam int BPW    = `DMA_BYTES_PER_WORD;  // bytes per data word
  localparam int IDX_W  = $clog2(BPW);          // width of a mask table index
  localparam int SIZE_W = IDX_W + 1;            // a transfer size reaches a full word

  logic [ADDR_W-1:0] address_counter; // word aligned address of the next write
  logic [LEN_W-1:0]  length_counter;  // bytes still to be written
  logic [SIZE_W-1:0] transfer_size;   // bytes carried by the current write
  logic [IDX_W-1:0]  mask_index;      // transfer size minus one
  byteenable_t       byteenable_masks [BPW]; // lowest k+1 lanes enabled at index k
  byteenable_t       byteenable;      // enables picked for the current write
  logic              go;              // a descriptor is accepted this cycle
  logic              write;           // a write is presented this cycle
  logic              write_complete;  // the fabric takes the write this cycle
  logic              idle;            // nothing left to transfer
  logic              idle_d1;         // idle one cycle earlier for edge detection

  // the master is idle exactly when no bytes remain
  assign idle          = (length_counter == '0);
  assign command_ready = idle;
  assign go            = command_valid & command_ready; // handshake on the descriptor port

  // a write goes out whenever there are bytes left and a word is buffered
  assign write          = ~idle & ~fifo_empty;
  assign write_complete = write & ~master_waitrequest; // waitrequest low means the fabric took it
  assign fifo_read      = write_complete;               // exactly one word leaves per write

  // full words until the tail and then whatever is left of the length
  always_comb
  begin
    if (length_counter < LEN_W'(BPW))
    begin
      transfer_size = length_counter[SIZE_W-1:0]; // partial last word
    end
    else
    begin
      transfer_size = SIZE_W'(BPW); // normal full word write
    end
  end

  // table of contiguous lane masks starting at lane zero
  for (genvar k = 0; k < BPW; k++)
  begin : g_mask
    assign byteenable_masks[k] = byteenable_t'((1 << (k + 1)) - 1); // k+1 low bits set
  end

  assign mask_index = IDX_W'(transfer_size - 1'b1); // size of one picks the first entry
  assign byteenable = byteenable_masks[mask_index];  // only read while a write is pending

  // the done strobe fires on the cycle idle rises
  assign response_valid = idle & ~idle_d1;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      address_counter <= '0;
      length_counter  <= '0;  // master comes out of reset idle
      idle_d1         <= 1'b1; // treating the reset cycle as idle keeps the strobe quiet
    end
    else
    begin
      idle_d1 <= idle;
      if (go)
      begin
        // low address bits are dropped so every access is aligned
        address_counter <= command_data.address & ~ADDR_W'(BPW - 1);
        length_counter  <= command_data.length; // a zero length loads zero and stays idle
      end
      else if (write_complete)
      begin
        address_counter <= address_counter + ADDR_W'(BPW);         // step to the next word
        length_counter  <= length_counter - LEN_W'(transfer_size); // count down what was written
      end
    end
  end

  // the request only moves when a write completes so it holds under waitrequest
  always_comb
  begin
    master.write      = write;
    master.address    = address_counter;
    master.byteenable = byteenable;
    master.writedata  = fifo_q; // the FIFO already holds little endian words
  end

endmodule

`default_nettype wire

// File: src/dma_write_top.sv
`default_nettype none
`timescale 1ns/10ps

`include "dma_cfg.svh"

module dma_write_top
  import stream_pkg::*;
  import command_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        command_valid,      // descriptor handshake
  input  descriptor_t command_data,
  output logic        command_ready,
  input  st_beat_t    snk,                // streaming beats in network order
  output logic        snk_ready,          // low while the FIFO has no room
  output master_cmd_t master,             // memory-mapped write request
  input  logic        master_waitrequest,
  output logic        response_valid      // pulse at the end of each descriptor
);

  localparam int DATA_W = `DMA_DATA_WIDTH;
  localparam int BPW    = `DMA_BYTES_PER_WORD;

  logic         fifo_write; // an accepted beat goes straight into the FIFO
  stream_word_t fifo_data;  // accepted beat after the byte swap
  logic         fifo_read;  // pop driven by completed writes
  stream_word_t fifo_q;     // show-ahead head word
  logic         fifo_full;
  logic         fifo_empty;

  // the stream sink is purely combinational so it lives here in the top
  assign snk_ready  = ~fifo_full;              // accept only when a slot is free
  assign fifo_write = snk.valid & snk_ready;   // zero cycles from beat to push

  // network order puts the first byte in the top lane and memory wants it in lane zero
  for (genvar b = 0; b < BPW; b++)
  begin : g_swap
    assign fifo_data[8*b +: 8] = snk.data[DATA_W - 8*(b + 1) +: 8];
  end

  write_fifo #(
    .DEPTH_LOG2 (`DMA_FIFO_DEPTH_LOG2)
  ) u_write_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .fifo_write (fifo_write),
    .fifo_data  (fifo_data),
    .fifo_read  (fifo_read),
    .fifo_q     (fifo_q),
    .fifo_full  (fifo_full),
    .fifo_empty (fifo_empty)
  );

  write_master u_write_master (
    .clk                (clk),
    .rst_n              (rst_n),
    .command_valid      (command_valid),
    .command_data       (command_data),
    .command_ready      (command_ready),
    .fifo_q             (fifo_q),
    .fifo_empty         (fifo_empty),
    .fifo_read          (fifo_read),
    .master             (master),
    .master_waitrequest (master_waitrequest),
    .response_valid     (response_valid)
  );

endmodule

`default_nettype wire

// File: testbench/tb_dma_write.sv
`default_nettype none
`timescale 1ns/10ps

`include "dma_cfg.svh"

module tb_dma_write
  import stream_pkg::*;
  import command_pkg::*;
  ();

  localparam int CLK_PERIOD   = 8;                            // ns
  localparam int NUM_TESTS    = 40;                           // descriptors in the run
  localparam int MAX_LEN      = 64;                           // longest descriptor in bytes
  localparam int BPW          = `DMA_BYTES_PER_WORD;
  localparam int FIFO_DEPTH   = 2 ** `DMA_FIFO_DEPTH_LOG2;    // words before snk_ready drops
  localparam int MAX_BEATS    = NUM_TESTS * MAX_LEN / BPW;    // upper bound on stream words
  localparam int MEM_BYTES    = 8192;                         // 4 KB window plus the longest tail
  localparam int WAIT_PAT_LEN = 4096;                         // waitrequest pattern repeats after this
  localparam int HOLD_TEST    = 20;                           // back-pressure phase starts here
  localparam int HOLD_CYCLES  = 80;                           // long enough to fill the FIFO
  localparam int WATCHDOG_NS  = NUM_TESTS * 64 * 20 * CLK_PERIOD;

  logic        clk;
  logic        rst_n;
  logic        command_valid;
  descriptor_t command_data;
  logic        command_ready;
  st_beat_t    snk;
  logic        snk_ready;
  master_cmd_t master;
  logic        master_waitrequest;
  logic        response_valid;

  integer      seed;                        // shared by every $random call and all of them run at time 0
  logic [31:0] desc_addr [NUM_TESTS];
  logic [31:0] desc_len  [NUM_TESTS];
  int          cmd_gap   [NUM_TESTS];       // idle cycles after each descriptor handshake
  logic [31:0] beat_word [MAX_BEATS];       // stream words in network byte order
  int          beat_gap  [MAX_BEATS];       // valid low cycles after each beat
  int          num_beats;
  logic        wait_pat  [WAIT_PAT_LEN];    // random waitrequest that is high about 30% of cycles
  logic [7:0]  byte_q    [$];               // bytes of the stream in the order they were sent

  logic [7:0]  mem_model [MEM_BYTES];       // byte addressed image of the fabric
  logic [31:0] cur_addr;                    // descriptor being transferred
  logic [31:0] cur_len;
  logic [31:0] exp_addr;                    // address the next write must use
  logic [31:0] remaining;                   // model of the length counter
  int          writes_seen;
  int          occupancy;                   // words the FIFO should hold
  int          accepted;                    // descriptors taken so far
  int          cur_test;
  logic        resp_due;                    // the last write completed on the previous edge
  logic        hold_pending;                // a write was stalled on the previous edge
  master_cmd_t held_cmd;
  logic        hold_active;                 // waitrequest is forced high
  logic        hold_done;
  logic        full_seen;                   // snk_ready went low during the forced hold
  int          error_count;
  int          test_errors;
  int          tests_done;
  int          tests_failed;

  dma_write_top UUT (
    .clk                (clk),
    .rst_n              (rst_n),
    .command_valid      (command_valid),
    .command_data       (command_data),
    .command_ready      (command_ready),
    .snk                (snk),
    .snk_ready          (snk_ready),
    .master             (master),
    .master_waitrequest (master_waitrequest),
    .response_valid     (response_valid)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  task automatic report_mismatch(input string name, input logic [71:0] got,
                                 input logic [71:0] exp);
    begin
      $display("mismatch %s got %0h expected %0h at %0t", name, got, exp, $time);
      error_count++;
      test_errors++;
    end
  endtask

  task automatic report_failure(input string what);
    begin
      $display("%s at %0t", what, $time);
      error_count++;
      test_errors++;
    end
  endtask

  // lowest lanes up to the remaining length or all of them for a full word
  function automatic byteenable_t tail_enable(input logic [31:0] rem);
    begin
      if (rem >= BPW)
        tail_enable = '1;
      else
        tail_enable = byteenable_t'((1 << rem) - 1);
    end
  endfunction

  task automatic generate_stimulus;
    int         i;
    int         w;
    int         b;
    logic [7:0] bytes [BPW];
    begin
      num_beats = 0;
      for (i = 0; i < NUM_TESTS; i++)
      begin
        desc_addr[i] = ({$random(seed)} % 1024) * BPW; // aligned inside a 4 KB window
        desc_len[i]  = ({$random(seed)} % MAX_LEN) + 1;
        cmd_gap[i]   = {$random(seed)} % 4;
        for (w = 0; w < (desc_len[i] + BPW - 1) / BPW; w++)
        begin
          for (b = 0; b < BPW; b++)
          begin
            bytes[b] = 8'($random(seed));
            byte_q.push_back(bytes[b]); // tail padding is queued too and dropped per test
          end
          beat_word[num_beats] = {bytes[0], bytes[1], bytes[2], bytes[3]}; // first byte on top
          beat_gap[num_beats]  = {$random(seed)} % 4;
          num_beats++;
        end
      end
      for (i = 0; i < WAIT_PAT_LEN; i++)
      begin
        wait_pat[i] = (({$random(seed)} % 10) < 3);
      end
    end
  endtask

  task automatic drive_commands;
    int i;
    int g;
    begin
      for (i = 0; i < NUM_TESTS; i++)
      begin
        @(negedge clk);
        command_valid        = 1'b1;
        command_data.address = desc_addr[i];
        command_data.length  = desc_len[i];
        @(posedge clk);
        while (!command_ready)
        begin
          @(posedge clk); // the master is still busy with the previous descriptor
        end
        @(negedge clk);
        command_valid = 1'b0;
        for (g = 0; g < cmd_gap[i]; g++)
        begin
          @(negedge clk);
        end
      end
    end
  endtask

  task automatic drive_stream;
    int i;
    int g;
    begin
      for (i = 0; i < num_beats; i++)
      begin
        @(negedge clk);
        snk.valid = 1'b1;
        snk.data  = beat_word[i];
        @(posedge clk);
        while (!snk_ready)
        begin
          @(posedge clk); // FIFO full so the beat waits
        end
        @(negedge clk);
        snk.valid = 1'b0;
        for (g = 0; g < beat_gap[i]; g++)
        begin
          @(negedge clk);
        end
      end
    end
  endtask

  task automatic drive_waitrequest;
    int cyc;
    int h;
    begin
      cyc = 0;
      forever
      begin
        @(negedge clk);
        if (tests_done == HOLD_TEST && !hold_done)
        begin
          hold_active        = 1'b1; // no pops so the stream must fill the FIFO
          master_waitrequest = 1'b1;
          for (h = 0; h < HOLD_CYCLES; h++)
          begin
            @(negedge clk);
          end
          hold_active = 1'b0;
          hold_done   = 1'b1;
          if (!full_seen)
            report_failure("snk_ready never dropped while waitrequest held the master");
        end
        master_waitrequest = wait_pat[cyc % WAIT_PAT_LEN];
        cyc++;
      end
    end
  endtask

  task automatic start_test;
    int j;
    begin
      cur_test    = accepted;
      accepted++;
      cur_addr    = command_data.address;
      cur_len     = command_data.length;
      exp_addr    = cur_addr & ~32'(BPW - 1); // low address bits are ignored
      remaining   = cur_len;
      writes_seen = 0;
      test_errors = 0;
      for (j = 0; j < cur_len; j++)
      begin
        mem_model[(cur_addr + j) % MEM_BYTES] = 8'hxx; // unwritten bytes cannot match by chance
      end
    end
  endtask

  task automatic finish_test;
    int         j;
    int         words;
    logic [7:0] exp_byte;
    logic [7:0] got_byte;
    begin
      words = (cur_len + BPW - 1) / BPW;
      if (writes_seen != words)
        report_mismatch("write count", writes_seen, words);
      for (j = 0; j < cur_len; j++)
      begin
        exp_byte = byte_q.pop_front();
        got_byte = mem_model[(cur_addr + j) % MEM_BYTES];
        if (got_byte !== exp_byte)
          report_mismatch($sformatf("mem[%h]", cur_addr + j), got_byte, exp_byte);
      end
      for (j = cur_len; j < words * BPW; j++)
      begin
        exp_byte = byte_q.pop_front(); // padding of the last stream word
      end
      if (test_errors == 0)
      begin
        $display("test %0d addr %h len %0d writes %0d ok", cur_test, cur_addr, cur_len,
                 writes_seen);
      end
      else
      begin
        $display("test %0d addr %h len %0d failed with %0d errors", cur_test, cur_addr,
                 cur_len, test_errors);
        tests_failed++;
      end
      tests_done++;
    end
  endtask

  // samples on the rising edge where every output has settled since the falling edge drive
  always @(posedge clk)
  begin : monitor
    int b;
    if (rst_n)
    begin
      if (snk_ready !== (occupancy < FIFO_DEPTH))
        report_mismatch("snk_ready", snk_ready, occupancy < FIFO_DEPTH);
      if (hold_active && !snk_ready)
        full_seen = 1'b1;
      if (master.write !== (remaining != 0 && occupancy != 0))
        report_mismatch("master.write", master.write, remaining != 0 && occupancy != 0);
      if (command_ready !== (remaining == 0))
        report_mismatch("command_ready", command_ready, remaining == 0);
      if (response_valid !== resp_due)
        report_mismatch("response_valid", response_valid, resp_due);
      if (hold_pending && master !== held_cmd)
        report_mismatch("master", master, held_cmd); // stalled request moved
      hold_pending = master.write && master_waitrequest;
      held_cmd     = master;
      resp_due     = 1'b0;
      if (master.write && !master_waitrequest)
      begin
        if (remaining == 0)
        begin
          report_failure("write completed with no descriptor in progress");
        end
        else
        begin
          if (master.address !== exp_addr)
            report_mismatch("master.address", master.address, exp_addr);
          if (master.byteenable !== tail_enable(remaining))
            report_mismatch("master.byteenable", master.byteenable, tail_enable(remaining));
          for (b = 0; b < BPW; b++)
          begin
            if (master.byteenable[b])
              mem_model[(master.address + b) % MEM_BYTES] = master.writedata[8*b +: 8];
          end
          exp_addr  = exp_addr + BPW;
          remaining = remaining - ((remaining < BPW) ? remaining : BPW);
          writes_seen++;
          if (remaining == 0)
            resp_due = 1'b1; // pulse expected on the next edge
        end
      end
      if (response_valid)
      begin
        if (tests_done >= accepted)
          report_failure("response pulse with no outstanding descriptor");
        else
          finish_test();
      end
      if (command_valid && command_ready)
        start_test();
      if (snk.valid && snk_ready)
        occupancy++;
      if (master.write && !master_waitrequest)
        occupancy--;
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns with %0d of %0d descriptors done", WATCHDOG_NS,
             tests_done, NUM_TESTS);
    $display("Errors found");
    $finish;
  end

  initial
  begin
    seed               = 23;
    rst_n              = 1'b0;
    command_valid      = 1'b0;
    command_data       = '0;
    snk                = '0;
    master_waitrequest = 1'b0;
    remaining          = '0;
    exp_addr           = '0;
    cur_addr           = '0;
    cur_len            = '0;
    writes_seen        = 0;
    occupancy          = 0;
    accepted           = 0;
    cur_test           = 0;
    resp_due           = 1'b0;
    hold_pending       = 1'b0;
    held_cmd           = '0;
    hold_active        = 1'b0;
    hold_done          = 1'b0;
    full_seen          = 1'b0;
    error_count        = 0;
    test_errors        = 0;
    tests_done         = 0;
    tests_failed       = 0;
    generate_stimulus();
    repeat (8) @(negedge clk); // reset spans eight rising edges
    rst_n = 1'b1;
    fork
      drive_commands();
      drive_stream();
      drive_waitrequest();
    join_none
    wait (tests_done == NUM_TESTS);
    repeat (4) @(posedge clk);
    if (occupancy != 0)
      report_failure("FIFO still holds words after the last descriptor");
    $display("tests %0d passed %0d failed %0d errors %0d", tests_done,
             tests_done - tests_failed, tests_failed, error_count);
    if (error_count == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+src
src/stream_pkg.sv
src/command_pkg.sv
src/write_fifo.sv
src/write_master.sv
src/dma_write_top.sv
testbench/tb_dma_write.sv

// File: run.sh
#!/bin/sh
verilator --binary --timing -Wno-fatal -f src.f --top-module tb_dma_write -o tb_dma_write \
  && ./obj_dir/tb_dma_write | tee /dev/stderr | grep -q "^No errors$" \
  || { echo "simulation failed"; exit 1; }
exit 0
